// ==== tb.f ====
common/ringPkg.sv
logic/ringBridge.sv
wbStop/wbStopCtrl.sv
wbStop/ringInjector.sv
logic/ringMemNode.sv
logic/ringSubsystem.sv
verification/tbClockGen.sv
verification/ringSubsystemTb.sv

// ==== verification/ringSubsystemTb.sv ====
// Testbench for the ring memory subsystem, built with memWords = 64.
// Word addresses 64 and up must end in err. Reads of never-written words
// are not checked. Bus inputs change only on rising clock edges.
`timescale 1ns/1ps

module ringSubsystemTb;
	import ringPkg::*;

	localparam int memWords = 64;
	localparam int resetCycles = 16;
	localparam int idleChecks = 6;
	localparam int numRandom = 40;
	localparam int cyclesPerTx = 200;

	typedef struct packed {
		logic isWrite;
		logic [31:0] wordAddr;
		logic [31:0] data;
		logic expErr;
		logic [31:0] expRead;
	} tableEntryT;

	logic clock;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	wbAddrT adr;
	wbDataT datW;
	wbDataT datR;
	logic ack;
	logic err;

	tableEntryT vecTable [$];
	wbDataT refMem [memWords]; // predicted memory contents
	logic refValid [memWords];
	logic [31:0] lfsr = 32'he6b9_8123;
	int errorCount = 0;
	int txCount = 0;
	int respCount = 0;
	int cycleCount = 0;
	int limitCycles;
	logic ackPrev = 1'b0;
	logic errPrev = 1'b0;

	tbClockGen #(
		.periodNs(10),
		.resetCycles(resetCycles)
	) tbClockGen_i (
		.clock(clock),
		.rstN(rstN)
	);

	ringSubsystem #(
		.nodeTag(6'h05),
		.memWords(memWords)
	) ringSubsystem_i (
		.clock(clock),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.datR(datR),
		.ack(ack),
		.err(err)
	);

	// Galois LFSR, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] result;
		logic outBit;
		result = '0;
		for (int k = 0; k < n; k++)
		begin
			outBit = lfsr[0];
			lfsr = lfsr >> 1;
			if (outBit)
				lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
			result = {result[30:0], outBit};
		end
		return result;
	endfunction

	task automatic addEntry(input logic isWrite, input logic [31:0] wordAddr,
		input logic [31:0] data, input logic expErr, input logic [31:0] expRead);
		vecTable.push_back({isWrite, wordAddr, data, expErr, expRead});
	endtask

	// called right after a rising edge, returns at the edge that sees ack or err
	task automatic runTransaction(input logic isWrite, input logic [31:0] wordAddr,
		input logic [31:0] data, output logic gotAck, output logic gotErr,
		output logic [31:0] gotData);
		logic done;
		done = 1'b0;
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= isWrite;
		adr <= {wordAddr[29:0], 2'b00}; // word to byte address
		datW <= data;
		while (!done)
		begin
			@(posedge clock);
			if (ack || err)
			begin
				done = 1'b1;
				gotAck = ack;
				gotErr = err;
				gotData = datR;
			end
		end
		txCount++;
	endtask

	task automatic checkResult(input logic isWrite, input logic [31:0] wordAddr,
		input logic expErr, input logic checkRead, input logic [31:0] expRead,
		input logic gotAck, input logic gotErr, input logic [31:0] gotData);
		assert (gotAck == !expErr)
		else
		begin
			$display("ERR ack word %h: got %h expected %h", wordAddr, gotAck, !expErr);
			errorCount++;
		end
		assert (gotErr == expErr)
		else
		begin
			$display("ERR err word %h: got %h expected %h", wordAddr, gotErr, expErr);
			errorCount++;
		end
		if (!isWrite && !expErr && checkRead)
		begin
			assert (gotData == expRead)
			else
			begin
				$display("ERR datR word %h: got %h expected %h", wordAddr, gotData, expRead);
				errorCount++;
			end
		end
	endtask

	// every response lasts one cycle, never ack and err together
	always @(posedge clock)
	begin
		if (rstN)
		begin
			assert (!(ack && err))
			else
			begin
				$display("ERR ack/err both high: ack %h err %h", ack, err);
				errorCount++;
			end
			assert (!(ack && ackPrev))
			else
			begin
				$display("ERR ack held a second cycle: got %h expected %h", ack, 1'b0);
				errorCount++;
			end
			assert (!(err && errPrev))
			else
			begin
				$display("ERR err held a second cycle: got %h expected %h", err, 1'b0);
				errorCount++;
			end
			if (ack || err)
				respCount++;
		end
		ackPrev = ack;
		errPrev = err;
	end

	initial
	begin
		tableEntryT e;
		logic gotAck;
		logic gotErr;
		logic [31:0] gotData;
		logic rWe;
		logic [31:0] rAddr;
		logic [31:0] rData;
		int gap;

		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datW = '0;
		for (int k = 0; k < memWords; k++)
			refValid[k] = 1'b0;

		addEntry(1'b1, 32'd0, 32'h1111_0000, 1'b0, 32'h0); // first word
		addEntry(1'b0, 32'd0, 32'h0, 1'b0, 32'h1111_0000);
		addEntry(1'b1, 32'd31, 32'hA5A5_5A5A, 1'b0, 32'h0); // middle
		addEntry(1'b0, 32'd31, 32'h0, 1'b0, 32'hA5A5_5A5A);
		addEntry(1'b1, 32'd63, 32'hDEAD_BEEF, 1'b0, 32'h0); // last
		addEntry(1'b0, 32'd63, 32'h0, 1'b0, 32'hDEAD_BEEF);
		addEntry(1'b1, 32'd64, 32'h0BAD_0BAD, 1'b1, 32'h0); // past the end
		addEntry(1'b0, 32'd64, 32'h0, 1'b1, 32'h0);
		addEntry(1'b0, 32'd63, 32'h0, 1'b0, 32'hDEAD_BEEF);
		addEntry(1'b0, 32'd0, 32'h0, 1'b0, 32'h1111_0000); // would alias word 0
		addEntry(1'b1, 32'd127, 32'h1234_5678, 1'b1, 32'h0);
		addEntry(1'b0, 32'd63, 32'h0, 1'b0, 32'hDEAD_BEEF); // would alias word 63
		addEntry(1'b0, 32'h3FFF_FFFF, 32'h0, 1'b1, 32'h0);
		addEntry(1'b1, 32'd31, 32'hC0FF_EE00, 1'b0, 32'h0); // overwrite
		addEntry(1'b1, 32'd30, 32'h3030_3030, 1'b0, 32'h0);
		addEntry(1'b1, 32'd32, 32'h3232_3232, 1'b0, 32'h0);
		addEntry(1'b0, 32'd31, 32'h0, 1'b0, 32'hC0FF_EE00);
		addEntry(1'b0, 32'd30, 32'h0, 1'b0, 32'h3030_3030);
		addEntry(1'b0, 32'd32, 32'h0, 1'b0, 32'h3232_3232);

		wait (rstN === 1'b1);
		repeat (idleChecks)
		begin
			@(posedge clock);
			assert (!ack && !err)
			else
			begin
				$display("ERR ack %h err %h with no cycle, expected 0", ack, err);
				errorCount++;
			end
		end

		foreach (vecTable[i])
		begin
			e = vecTable[i];
			runTransaction(e.isWrite, e.wordAddr, e.data, gotAck, gotErr, gotData);
			cyc <= 1'b0;
			stb <= 1'b0;
			checkResult(e.isWrite, e.wordAddr, e.expErr, 1'b1, e.expRead,
				gotAck, gotErr, gotData);
			if (e.isWrite && !e.expErr)
			begin
				refMem[e.wordAddr[5:0]] = e.data;
				refValid[e.wordAddr[5:0]] = 1'b1;
			end
			@(posedge clock);
		end

		for (int n = 0; n < numRandom; n++)
		begin
			rWe = (randBits(1) != 0);
			rAddr = randBits(6); // always in range
			rData = randBits(32);
			gap = int'(randBits(2));
			runTransaction(rWe, rAddr, rData, gotAck, gotErr, gotData);
			checkResult(rWe, rAddr, 1'b0, refValid[rAddr[5:0]], refMem[rAddr[5:0]],
				gotAck, gotErr, gotData);
			if (rWe)
			begin
				refMem[rAddr[5:0]] = rData;
				refValid[rAddr[5:0]] = 1'b1;
			end
			if (gap > 0)
			begin
				cyc <= 1'b0;
				stb <= 1'b0;
				repeat (gap)
					@(posedge clock);
			end
		end
		cyc <= 1'b0;
		stb <= 1'b0;
		repeat (4)
			@(posedge clock); // monitor sees the last ack drop

		assert (respCount == txCount)
		else
		begin
			$display("Bus responses (%0d) do not match transactions issued (%0d)",
				respCount, txCount);
			errorCount++;
		end
		$display("Done: %0d transactions, %0d responses, %0d errors",
			txCount, respCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	initial
	begin
		wait (rstN === 1'b1);
		limitCycles = resetCycles + idleChecks + cyclesPerTx * (vecTable.size() + numRandom);
		wait (cycleCount >= limitCycles);
		$display("Timeout: the bus stopped answering, run ended after %0d clock cycles",
			cycleCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verification/tbClockGen.sv ====
// Testbench clock and reset source.
// rstN is released on a rising edge after resetCycles cycles.
`timescale 1ns/1ps

module tbClockGen #(
	parameter int periodNs = 10,
	parameter int resetCycles = 16
) (
	output logic clock,
	output logic rstN
);

	initial
	begin
		clock = 1'b0;
		forever
			#(periodNs / 2) clock = ~clock;
	end

	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles)
			@(posedge clock);
		rstN <= 1'b1; // released like any other input
	end

endmodule

// ==== logic/ringSubsystem.sv ====
// Top level: Wishbone classic slave port onto an L1 ring, bridged to an
// L2 ring holding one memory node. Single 32-bit word accesses only.
// adr is a byte address; its low two bits are ignored.
`timescale 1ns/1ps

module ringSubsystem #(
	parameter logic [5:0] nodeTag = 6'h01,
	parameter int memWords = 64
) (
	input logic clock,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input ringPkg::wbAddrT adr,
	input ringPkg::wbDataT datW,
	output ringPkg::wbDataT datR,
	output logic ack,
	output logic err
);
	import ringPkg::*;

	ringPacketT l1ToBridge; // injector to bridge
	ringPacketT l1FromBridge;
	ringPacketT l2ToMem;
	ringPacketT l2FromMem;
	ringPacketT request;
	ringPacketT response;
	logic issue;
	logic injected;
	logic respValid;

	wbStopCtrl #(
		.nodeTag(nodeTag)
	) wbStopCtrl_i (
		.clock(clock),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.datR(datR),
		.ack(ack),
		.err(err),
		.issue(issue),
		.request(request),
		.injected(injected),
		.respValid(respValid),
		.response(response)
	);

	ringInjector #(
		.nodeTag(nodeTag)
	) ringInjector_i (
		.clock(clock),
		.rstN(rstN),
		.ringIn(l1FromBridge),
		.ringOut(l1ToBridge),
		.issue(issue),
		.request(request),
		.injected(injected),
		.respValid(respValid),
		.response(response)
	);

	ringBridge #(
		.nodeTag(nodeTag)
	) ringBridge_i (
		.clock(clock),
		.rstN(rstN),
		.l1In(l1ToBridge),
		.l2In(l2FromMem),
		.l1Out(l1FromBridge),
		.l2Out(l2ToMem)
	);

	ringMemNode #(
		.memWords(memWords)
	) ringMemNode_i (
		.clock(clock),
		.rstN(rstN),
		.ringIn(l2ToMem),
		.ringOut(l2FromMem)
	);

endmodule

// ==== logic/ringMemNode.sv ====
// Memory node on the L2 ring, memWords words of 32 bits.
// Contents are not cleared by reset.
// Addresses on the ring are word addresses; anything at or past memWords
// is answered with an error response and leaves the memory untouched.
`timescale 1ns/1ps

module ringMemNode #(
	parameter int memWords = 64
) (
	input logic clock,
	input logic rstN,
	input ringPkg::ringPacketT ringIn,
	output ringPkg::ringPacketT ringOut
);
	import ringPkg::*;

	localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

	wbDataT mem [memWords];
	logic isReq;
	logic isStore;
	logic inRange;
	logic [idxW-1:0] idx;
	ringPacketT resp;

	assign isReq = (ringIn.opm[7:6] == 2'b10);
	assign isStore = (ringIn.opm == opmStoreReq);
	assign inRange = (ringIn.addr < ringAddrT'(memWords));
	assign idx = ringIn.addr[idxW-1:0];

	// response keeps seq and addr, other request opms act as loads
	always_comb
	begin
		resp = ringIn;
		if (!inRange)
			resp.opm = opmErrResp;
		else if (isStore)
			resp.opm = opmStoreResp; // echoes the written data
		else
		begin
			resp.opm = opmLoadResp;
			resp.data = ringDataT'(mem[idx]);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			ringOut <= pktIdle;
		else
			ringOut <= isReq ? resp : ringIn; // responses circulate unchanged
	end

	always_ff @(posedge clock)
	begin
		if (rstN && isStore && inRange)
			mem[idx] <= ringIn.data[31:0];
	end

endmodule

// ==== wbStop/ringInjector.sv ====
// L1 ring stage of the Wishbone stop.
// Takes responses tagged with nodeTag off the ring and inserts the
// pending request into an empty slot or the slot just freed.
// All other packets pass after one register.
`timescale 1ns/1ps

module ringInjector #(
	parameter logic [5:0] nodeTag = 6'h01
) (
	input logic clock,
	input logic rstN,
	input ringPkg::ringPacketT ringIn,
	output ringPkg::ringPacketT ringOut,
	input logic issue,
	input ringPkg::ringPacketT request,
	output logic injected,
	output logic respValid,
	output ringPkg::ringPacketT response
);
	import ringPkg::*;

	logic slotIdle;
	logic ownResp;

	assign slotIdle = (ringIn.opm[7:0] == opmIdle[7:0]);
	assign ownResp = (ringIn.opm[7:6] == 2'b01) && (ringIn.seq[15:10] == nodeTag);
	assign injected = issue && (slotIdle || ownResp); // slot usable this cycle

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ringOut <= pktIdle;
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= ownResp;
			if (injected)
				ringOut <= request;
			else if (ownResp)
				ringOut <= pktIdle; // consumed, slot freed
			else
				ringOut <= ringIn;
		end
	end

	always_ff @(posedge clock)
	begin
		if (ownResp)
			response <= ringIn;
	end

endmodule

// ==== wbStop/wbStopCtrl.sv ====
// Wishbone classic slave state machine for the L1 ring stop.
// Single 32-bit reads and writes only. No byte selects, no bursts.
// One transaction in flight at a time. Every request gets an answer,
// so there is no timeout.
`timescale 1ns/1ps

module wbStopCtrl #(
	parameter logic [5:0] nodeTag = 6'h01
) (
	input logic clock,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input ringPkg::wbAddrT adr,
	input ringPkg::wbDataT datW,
	output ringPkg::wbDataT datR,
	output logic ack,
	output logic err,
	output logic issue,
	output ringPkg::ringPacketT request,
	input logic injected,
	input logic respValid,
	input ringPkg::ringPacketT response
);
	import ringPkg::*;

	stopStateT state;
	logic [9:0] seqNum; // running number, wraps
	logic respErr;
	wbDataT respData;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			seqNum <= '0;
		end
		else
		begin
			case (state)
				sIdle:
					if (cyc && stb)
					begin
						state <= sIssue;
						seqNum <= seqNum + 10'd1;
					end
				sIssue:
					if (injected)
						state <= sWait;
				sWait:
					if (respValid)
						state <= sDone;
				default:
					state <= sIdle; // ack or err lasts one cycle
			endcase
		end
	end

	// request follows the bus while idle, frozen once accepted
	always_ff @(posedge clock)
	begin
		if (state == sIdle)
		begin
			request.seq <= {nodeTag, seqNum};
			request.opm <= we ? opmStoreReq : opmLoadReq;
			request.addr <= ringAddrT'(adr[31:2]); // byte to word address
			request.data <= ringDataT'(datW);
		end
		if ((state == sWait) && respValid)
		begin
			respErr <= (response.opm == opmErrResp);
			respData <= response.data[31:0];
		end
	end

	assign issue = (state == sIssue);
	assign ack = (state == sDone) && !respErr;
	assign err = (state == sDone) && respErr;
	assign datR = respData;

endmodule

// ==== logic/ringBridge.sv ====
// Moves requests from the L1 ring down to L2, and responses tagged with
// nodeTag from L2 back up to L1. One registered stage on each ring.
// A packet that cannot cross keeps circulating on its own ring until the
// other side offers an idle slot or a slot this bridge consumes.
`timescale 1ns/1ps

module ringBridge #(
	parameter logic [5:0] nodeTag = 6'h01
) (
	input logic clock,
	input logic rstN,
	input ringPkg::ringPacketT l1In,
	input ringPkg::ringPacketT l2In,
	output ringPkg::ringPacketT l1Out,
	output ringPkg::ringPacketT l2Out
);
	import ringPkg::*;

	logic l1Idle;
	logic l1IsReq;
	logic l2Idle;
	logic l2OwnResp;
	logic holdUp; // L1 slot busy with a foreign packet
	logic holdDown; // L2 slot busy with a foreign packet
	logic l1Take;
	logic l2Take;
	ringPacketT upPkt;
	ringPacketT downPkt;

	assign l1Idle = (l1In.opm[7:0] == opmIdle[7:0]);
	assign l1IsReq = (l1In.opm[7:6] == 2'b10);
	assign l2Idle = (l2In.opm[7:0] == opmIdle[7:0]);
	assign l2OwnResp = (l2In.opm[7:6] == 2'b01) && (l2In.seq[15:10] == nodeTag);

	assign holdUp = !l1Idle && !l1IsReq;
	assign holdDown = !l2Idle && !l2OwnResp;

	// crossing candidates, idle when nothing wants to move
	assign upPkt = l2OwnResp ? l2In : pktIdle;
	assign downPkt = l1IsReq ? l1In : pktIdle;

	// a slot is overwritten only if its own packet leaves at the same time
	assign l1Take = l1Idle || (l1IsReq && !holdDown);
	assign l2Take = l2Idle || (l2OwnResp && !holdUp);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			l1Out <= pktIdle;
			l2Out <= pktIdle;
		end
		else
		begin
			l1Out <= l1Take ? upPkt : l1In; // else forward as is
			l2Out <= l2Take ? downPkt : l2In;
		end
	end

endmodule

// ==== common/ringPkg.sv ====
// Shared types for the two-level ring memory subsystem.
// Only the low 32 bits of the 128-bit data field carry a value.
// The opm class sits in bits 7:6, and an all-zero low byte marks an idle slot.
// Sequence tag is seq[15:10]. Responses are routed back by this tag alone.
package ringPkg;

	typedef logic [15:0] ringSeqT; // tag 15:10, running number 9:0
	typedef logic [15:0] ringOpmT; // class in 7:6
	typedef logic [47:0] ringAddrT; // word address on the rings
	typedef logic [127:0] ringDataT;
	typedef logic [31:0] wbDataT;
	typedef logic [31:0] wbAddrT; // byte address on the bus

	typedef struct packed {
		ringSeqT seq;
		ringOpmT opm;
		ringAddrT addr;
		ringDataT data;
	} ringPacketT; // 208 bits

	localparam ringOpmT opmIdle = 16'h0000;
	localparam ringOpmT opmLoadReq = 16'h0080; // class 10
	localparam ringOpmT opmStoreReq = 16'h0081;
	localparam ringOpmT opmLoadResp = 16'h0040; // class 01
	localparam ringOpmT opmStoreResp = 16'h0041;
	localparam ringOpmT opmErrResp = 16'h0042; // address past the memory

	// empty slot as driven by every stage in reset
	localparam ringPacketT pktIdle = '{
		seq: '0,
		opm: opmIdle,
		addr: '0,
		data: '0
	};

	typedef enum logic [1:0] {
		sIdle,
		sIssue,
		sWait,
		sDone
	} stopStateT;

endpackage
